//--- common/armIsaPkg.sv
`include "ctrl_params.svh"

package armIsaPkg;

  // ============================================================
  // Plain vectors
  // ============================================================
  typedef logic [`INSTR_W-1:0] instrT;        // Raw instruction word
  typedef logic [`FLAG_W-1:0]  flagsT;        // {N, Z, C, V}
  typedef logic [3:0]          byteMaskT;     // One bit per byte lane
  typedef logic [1:0]          byteOffsetT;   // Address bits 1:0

  // ============================================================
  // Field encodings
  // ============================================================

  // Condition codes, in ARM encoding order
  typedef enum logic [`COND_MSB-`COND_LSB:0] {
    condEq, condNe,   // Z set / clear
    condCs, condCc,   // C set / clear
    condMi, condPl,   // N set / clear
    condVs, condVc,   // V set / clear
    condHi, condLs,   // Unsigned higher / lower or same
    condGe, condLt,   // Signed compares
    condGt, condLe,
    condAl, condNv    // Always / never
  } condT;

  // Data processing opcodes, bits 24:21
  typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
    opAnd, opEor, opSub, opRsb,
    opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn,   // Flags only, no Rd write
    opOrr, opMov, opBic, opMvn
  } aluOpT;

  typedef enum logic [`CLASS_MSB-`CLASS_LSB:0] {
    dataProc  = 2'b00,
    memAccess = 2'b01,   // LDR / STR
    branch    = 2'b10,   // B, shares the slot with LDM/STM
    other     = 2'b11    // Coprocessor and SWI
  } instrClassT;

endpackage

//--- common/ctrlPipePkg.sv
package ctrlPipePkg;

  // ============================================================
  // Decode stage bundle
  // ============================================================
  typedef struct packed {
    logic [1:0]       regSrc;       // [1] Rd as 2nd read (STR), [0] PC as Rn (B)
    logic [1:0]       immSrc;       // 00 rotated imm8, 01 imm12, 10 imm24
    logic             aluSrc;       // Immediate as operand B
    armIsaPkg::aluOpT aluControl;
    logic             flagWrite;    // S bit of a data processing op
    logic             memtoReg;
    logic             regWrite;
    logic             memWrite;
    logic             branch;
    logic             byteAccess;   // LDRB / STRB
    logic             pcSrc;        // Writes R15
  } decodeCtrlT;

  // Memory stage, already gated by the condition
  typedef struct packed {
    logic                  memWrite;
    logic                  memtoReg;
    logic                  regWrite;
    logic                  pcSrc;
    logic                  byteAccess;
    armIsaPkg::byteOffsetT byteOffset;
    armIsaPkg::byteMaskT   byteMask;   // Lane enables for the data memory
    logic                  setFlags;
    armIsaPkg::flagsT      nextFlags;
  } memCtrlT;

  // Writeback stage
  typedef struct packed {
    logic                  memtoReg;
    logic                  regWrite;
    logic                  pcSrc;
    logic                  loadByte;     // Datapath extracts one byte
    armIsaPkg::byteOffsetT byteOffset;
    logic                  setFlags;
    armIsaPkg::flagsT      nextFlags;
  } wbCtrlT;

endpackage

//--- common/ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// ============================================================
// Instruction word layout
// ============================================================
`define INSTR_W    32
`define COND_MSB   31   // Condition field
`define COND_LSB   28
`define CLASS_MSB  27   // Coarse class, bits 27:26
`define CLASS_LSB  26
`define I_BIT      25   // Immediate operand, or register offset for LDR/STR
`define OPC_MSB    24   // Data processing opcode
`define OPC_LSB    21
`define U_BIT      23   // Offset added when set
`define B_BIT      22   // Byte transfer
`define S_BIT      20   // Set flags on data processing
`define L_BIT      20   // Load when set, same bit as S
`define RD_MSB     15   // Destination register
`define RD_LSB     12
`define SH_REG_BIT 4    // Register-specified shift or multiply space

// ============================================================
// Status flags and register numbers
// ============================================================
`define FLAG_W     4
`define FLAG_N     3
`define FLAG_Z     2
`define FLAG_C     1
`define FLAG_V     0
`define RD_PC      15   // R15 is the PC

`endif

//--- decode/instrDecoder.sv
`timescale 1ns/1ps
`include "ctrl_params.svh"

module instrDecoder (
  input  armIsaPkg::instrT        instrD,
  output ctrlPipePkg::decodeCtrlT decodeCtrl,
  output logic                    pcSrcD
);

  armIsaPkg::instrClassT          instrClass;
  armIsaPkg::aluOpT               opcode;
  logic [`RD_MSB-`RD_LSB:0]       rd;
  logic                           isCompare;   // TST, TEQ, CMP, CMN
  logic                           dpLegal;     // Data processing form we support

  // ============================================================
  // Field extraction
  // ============================================================
  assign instrClass = armIsaPkg::instrClassT'(instrD[`CLASS_MSB:`CLASS_LSB]);
  assign opcode     = armIsaPkg::aluOpT'(instrD[`OPC_MSB:`OPC_LSB]);
  assign rd         = instrD[`RD_MSB:`RD_LSB];

  assign isCompare = opcode inside {armIsaPkg::opTst, armIsaPkg::opTeq,
                                    armIsaPkg::opCmp, armIsaPkg::opCmn};

  // Register-shifted, multiply and halfword forms have bit 4 set in the
  // register form; compares without S are MRS/MSR/BX space
  assign dpLegal = (instrD[`I_BIT] | ~instrD[`SH_REG_BIT]) &
                   ~(isCompare & ~instrD[`S_BIT]);

  // ============================================================
  // Control word per class
  // ============================================================
  always_comb begin
    decodeCtrl            = '0;                      // No-op unless a group matches
    decodeCtrl.aluControl = armIsaPkg::opAdd;

    case (instrClass)
      armIsaPkg::dataProc: begin
        if (dpLegal) begin
          decodeCtrl.immSrc     = 2'b00;             // Rotated imm8
          decodeCtrl.aluSrc     = instrD[`I_BIT];
          decodeCtrl.aluControl = opcode;
          decodeCtrl.flagWrite  = instrD[`S_BIT];
          decodeCtrl.regWrite   = ~isCompare;        // Compares only touch flags
        end
      end

      armIsaPkg::memAccess: begin
        // I and bit 4 both set is the undefined space
        if (~(instrD[`I_BIT] & instrD[`SH_REG_BIT])) begin
          decodeCtrl.regSrc     = {~instrD[`L_BIT], 1'b0};   // STR reads Rd
          decodeCtrl.immSrc     = 2'b01;                     // imm12 offset
          decodeCtrl.aluSrc     = ~instrD[`I_BIT];           // I clear means immediate here
          decodeCtrl.aluControl = instrD[`U_BIT] ? armIsaPkg::opAdd : armIsaPkg::opSub;
          decodeCtrl.memtoReg   = instrD[`L_BIT];
          decodeCtrl.regWrite   = instrD[`L_BIT];
          decodeCtrl.memWrite   = ~instrD[`L_BIT];
          decodeCtrl.byteAccess = instrD[`B_BIT];
        end
      end

      armIsaPkg::branch: begin
        if (instrD[`I_BIT]) begin                    // LDM/STM have I clear
          decodeCtrl.regSrc = 2'b01;                 // PC as base
          decodeCtrl.immSrc = 2'b10;                 // imm24 word offset
          decodeCtrl.aluSrc = 1'b1;
          decodeCtrl.branch = 1'b1;
        end
      end

      default: begin
        // Coprocessor and SWI stay a no-op
      end
    endcase

    // Any write to R15 redirects fetch
    decodeCtrl.pcSrc = decodeCtrl.branch | (decodeCtrl.regWrite & (rd == `RD_PC));
  end

  assign pcSrcD = decodeCtrl.pcSrc;   // Hazard side copy

endmodule

//--- execute/condExecute.sv
`timescale 1ns/1ps
`include "ctrl_params.svh"

module condExecute (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    stallE,
  input  logic                    flushE,
  input  ctrlPipePkg::decodeCtrlT decodeCtrl,
  input  armIsaPkg::condT         condD,
  input  armIsaPkg::flagsT        aluFlagsE,
  input  armIsaPkg::byteOffsetT   aluAddrE,
  input  armIsaPkg::flagsT        fwdFlags,   // Newest NZCV, forwarded
  output armIsaPkg::aluOpT        aluControlE,
  output logic                    aluSrcE,
  output logic                    branchTakenE,
  output logic                    pcSrcE,     // Ungated, for PC-write pending
  output ctrlPipePkg::memCtrlT    memCtrlE
);

  ctrlPipePkg::decodeCtrlT ctrlE;
  armIsaPkg::condT         condE;
  armIsaPkg::byteMaskT     byteMaskE;
  logic                    flagN, flagZ, flagC, flagV;
  logic                    geE;         // Signed greater or equal
  logic                    condExE;     // Condition passes

  // ============================================================
  // D to E register
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrlE <= '0;
      condE <= armIsaPkg::condEq;
    end else if (!stallE) begin         // Enable first, then clear
      if (flushE) begin
        ctrlE <= '0;                    // Bubble
        condE <= armIsaPkg::condEq;
      end else begin
        ctrlE <= decodeCtrl;
        condE <= condD;
      end
    end
  end

  // ============================================================
  // Condition check
  // ============================================================
  assign flagN = fwdFlags[`FLAG_N];
  assign flagZ = fwdFlags[`FLAG_Z];
  assign flagC = fwdFlags[`FLAG_C];
  assign flagV = fwdFlags[`FLAG_V];
  assign geE   = (flagN == flagV);

  always_comb begin
    case (condE)
      armIsaPkg::condEq: condExE = flagZ;
      armIsaPkg::condNe: condExE = ~flagZ;
      armIsaPkg::condCs: condExE = flagC;
      armIsaPkg::condCc: condExE = ~flagC;
      armIsaPkg::condMi: condExE = flagN;
      armIsaPkg::condPl: condExE = ~flagN;
      armIsaPkg::condVs: condExE = flagV;
      armIsaPkg::condVc: condExE = ~flagV;
      armIsaPkg::condHi: condExE = flagC & ~flagZ;
      armIsaPkg::condLs: condExE = ~(flagC & ~flagZ);
      armIsaPkg::condGe: condExE = geE;
      armIsaPkg::condLt: condExE = ~geE;
      armIsaPkg::condGt: condExE = ~flagZ & geE;
      armIsaPkg::condLe: condExE = ~(~flagZ & geE);
      armIsaPkg::condAl: condExE = 1'b1;
      default:           condExE = 1'b0;   // NV
    endcase
  end

  // Byte store or load hits one lane, words hit all four
  assign byteMaskE = ctrlE.byteAccess ? armIsaPkg::byteMaskT'(4'b0001 << aluAddrE) : '1;

  // ============================================================
  // Gated bundle towards memory
  // ============================================================
  always_comb begin
    memCtrlE.memWrite   = ctrlE.memWrite & condExE;
    memCtrlE.memtoReg   = ctrlE.memtoReg;
    memCtrlE.regWrite   = ctrlE.regWrite & condExE;
    memCtrlE.pcSrc      = ctrlE.pcSrc & condExE;
    memCtrlE.byteAccess = ctrlE.byteAccess;
    memCtrlE.byteOffset = aluAddrE;
    memCtrlE.byteMask   = byteMaskE;
    memCtrlE.setFlags   = ctrlE.flagWrite & condExE;
    memCtrlE.nextFlags  = ctrlE.flagWrite ? aluFlagsE : fwdFlags;   // Else carry current
  end

  assign aluControlE  = ctrlE.aluControl;
  assign aluSrcE      = ctrlE.aluSrc;
  assign branchTakenE = ctrlE.branch & condExE;
  assign pcSrcE       = ctrlE.pcSrc;

endmodule

//--- result/statusWriteback.sv
`timescale 1ns/1ps

module statusWriteback (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 stallM,
  input  logic                 stallW,
  input  logic                 flushW,
  input  ctrlPipePkg::memCtrlT memCtrlE,
  input  logic                 pcSrcD,
  input  logic                 pcSrcE,
  output logic                 memWriteM,
  output logic                 memtoRegM,
  output logic                 regWriteM,
  output armIsaPkg::byteMaskT  byteMaskM,
  output ctrlPipePkg::wbCtrlT  wbCtrl,
  output armIsaPkg::flagsT     fwdFlags,
  output armIsaPkg::flagsT     flagsW,      // Architectural NZCV
  output logic                 pcWrPendingF
);

  ctrlPipePkg::memCtrlT memCtrlM;
  ctrlPipePkg::wbCtrlT  wbCtrlNext;
  armIsaPkg::flagsT     nzcv;

  // ============================================================
  // Memory stage
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rstN) memCtrlM <= '0;
    else if (!stallM) memCtrlM <= memCtrlE;     // Hold only, never flushed
  end

  assign memWriteM = memCtrlM.memWrite;
  assign memtoRegM = memCtrlM.memtoReg;
  assign regWriteM = memCtrlM.regWrite;
  assign byteMaskM = memCtrlM.byteMask;

  always_comb begin
    wbCtrlNext.memtoReg   = memCtrlM.memtoReg;
    wbCtrlNext.regWrite   = memCtrlM.regWrite;
    wbCtrlNext.pcSrc      = memCtrlM.pcSrc;
    wbCtrlNext.loadByte   = memCtrlM.byteAccess & memCtrlM.memtoReg;   // LDRB only
    wbCtrlNext.byteOffset = memCtrlM.byteOffset;
    wbCtrlNext.setFlags   = memCtrlM.setFlags;
    wbCtrlNext.nextFlags  = memCtrlM.nextFlags;
  end

  // ============================================================
  // Writeback stage and status register
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rstN || flushW) wbCtrl <= '0;          // Flush wins over stall here
    else if (!stallW) wbCtrl <= wbCtrlNext;
  end

  always_ff @(posedge clk) begin
    if (!rstN) nzcv <= '0;
    else if (wbCtrl.setFlags && !stallW) nzcv <= wbCtrl.nextFlags;
  end

  // Youngest pending update first
  assign fwdFlags = memCtrlM.setFlags ? memCtrlM.nextFlags :
                    wbCtrl.setFlags   ? wbCtrl.nextFlags   : nzcv;
  assign flagsW   = nzcv;

  // Fetch must wait while any R15 write is still in flight
  assign pcWrPendingF = pcSrcD | pcSrcE | memCtrlM.pcSrc;

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the armController testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --assert -Wno-fatal \
  --top-module armController_tb \
  -f verilog.f

# The log decides the verdict, so a failing run must not stop the script here
./obj_dir/VarmController_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "PASS: all tests" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- source/armController.sv
`timescale 1ns/1ps
`include "ctrl_params.svh"

module armController (
  input  logic                  clk,
  input  logic                  rstN,
  input  armIsaPkg::instrT      instrD,
  // From datapath
  input  armIsaPkg::flagsT      aluFlagsE,
  input  armIsaPkg::byteOffsetT aluAddrE,
  // From hazard unit
  input  logic                  stallE,
  input  logic                  flushE,
  input  logic                  stallM,
  input  logic                  stallW,
  input  logic                  flushW,
  // Decode
  output logic [1:0]            regSrcD,
  output logic [1:0]            immSrcD,
  // Execute
  output armIsaPkg::aluOpT      aluControlE,
  output logic                  aluSrcE,
  output logic                  branchTakenE,
  // Memory
  output logic                  memWriteM,
  output logic                  memtoRegM,
  output logic                  regWriteM,
  output armIsaPkg::byteMaskT   byteMaskM,
  // Writeback
  output logic                  regWriteW,
  output logic                  memtoRegW,
  output logic                  pcSrcW,
  output logic                  loadByteW,
  output armIsaPkg::byteOffsetT byteOffsetW,
  output armIsaPkg::flagsT      flagsW,
  output logic                  pcWrPendingF   // To hazard unit
);

  ctrlPipePkg::decodeCtrlT decodeCtrl;
  ctrlPipePkg::memCtrlT    memCtrlE;
  ctrlPipePkg::wbCtrlT     wbCtrl;
  armIsaPkg::flagsT        fwdFlags;
  logic                    pcSrcD;
  logic                    pcSrcE;

  instrDecoder u_decode (
    .instrD     (instrD),
    .decodeCtrl (decodeCtrl),
    .pcSrcD     (pcSrcD)
  );

  condExecute u_execute (
    .clk          (clk),
    .rstN         (rstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .decodeCtrl   (decodeCtrl),
    .condD        (armIsaPkg::condT'(instrD[`COND_MSB:`COND_LSB])),
    .aluFlagsE    (aluFlagsE),
    .aluAddrE     (aluAddrE),
    .fwdFlags     (fwdFlags),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .pcSrcE       (pcSrcE),
    .memCtrlE     (memCtrlE)
  );

  statusWriteback u_result (
    .clk          (clk),
    .rstN         (rstN),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushW       (flushW),
    .memCtrlE     (memCtrlE),
    .pcSrcD       (pcSrcD),
    .pcSrcE       (pcSrcE),
    .memWriteM    (memWriteM),
    .memtoRegM    (memtoRegM),
    .regWriteM    (regWriteM),
    .byteMaskM    (byteMaskM),
    .wbCtrl       (wbCtrl),
    .fwdFlags     (fwdFlags),
    .flagsW       (flagsW),
    .pcWrPendingF (pcWrPendingF)
  );

  // Datapath selects straight from decode
  assign regSrcD = decodeCtrl.regSrc;
  assign immSrcD = decodeCtrl.immSrc;

  assign regWriteW   = wbCtrl.regWrite;
  assign memtoRegW   = wbCtrl.memtoReg;
  assign pcSrcW      = wbCtrl.pcSrc;
  assign loadByteW   = wbCtrl.loadByte;
  assign byteOffsetW = wbCtrl.byteOffset;

endmodule

//--- tb/armController_sva.sv
`timescale 1ns/1ps

module armControllerSva (
  input logic                clk,
  input logic                rstN,
  input logic                memWriteM,
  input logic                regWriteM,
  input logic                regWriteW,
  input logic                pcSrcW,
  input logic                branchTakenE,
  input logic                pcWrPendingF,
  input armIsaPkg::byteMaskT byteMaskM
);

  // ============================================================
  // Control invariants
  // ============================================================

  // One reset edge clears every stage register
  resetClears: assert property (@(posedge clk)
      !rstN |=> !(memWriteM | regWriteM | regWriteW | pcSrcW))
    else $error("Write enable high after a reset cycle");

  takenIsPending: assert property (@(posedge clk) disable iff (!rstN)
      branchTakenE |-> pcWrPendingF)   // Taken branch writes R15
    else $error("Taken branch without a pending PC write");

  // Single lane or full word
  storeMask: assert property (@(posedge clk) disable iff (!rstN)
      memWriteM |-> ($onehot(byteMaskM) || byteMaskM == 4'hF))
    else $error("Store with an illegal byte mask");

endmodule

bind armController armControllerSva i_sva (
  .clk          (clk),
  .rstN         (rstN),
  .memWriteM    (memWriteM),
  .regWriteM    (regWriteM),
  .regWriteW    (regWriteW),
  .pcSrcW       (pcSrcW),
  .branchTakenE (branchTakenE),
  .pcWrPendingF (pcWrPendingF),
  .byteMaskM    (byteMaskM)
);

//--- tb/armController_tb.sv
`timescale 1ns/1ps
`include "ctrl_params.svh"

module armController_tb;

  localparam armIsaPkg::instrT nopInstr = 32'hEC00_0000;   // Coprocessor space, no writes
  localparam logic [3:0]       condAl   = 4'hE;

  logic                  clk;
  logic                  rstN;
  armIsaPkg::instrT      instrD;
  armIsaPkg::flagsT      aluFlagsE;
  armIsaPkg::byteOffsetT aluAddrE;
  logic                  stallE;
  logic                  flushE;
  logic                  stallM;
  logic                  stallW;
  logic                  flushW;
  logic [1:0]            regSrcD;
  logic [1:0]            immSrcD;
  armIsaPkg::aluOpT      aluControlE;
  logic                  aluSrcE;
  logic                  branchTakenE;
  logic                  memWriteM;
  logic                  memtoRegM;
  logic                  regWriteM;
  armIsaPkg::byteMaskT   byteMaskM;
  logic                  regWriteW;
  logic                  memtoRegW;
  logic                  pcSrcW;
  logic                  loadByteW;
  armIsaPkg::byteOffsetT byteOffsetW;
  armIsaPkg::flagsT      flagsW;
  logic                  pcWrPendingF;
  integer                seed;
  armIsaPkg::flagsT      curFlags;   // NZCV the model expects in writeback
  logic [1:0]            regSrcSeen; // Decode outputs of the last issued instruction
  logic [1:0]            immSrcSeen;

  armController i_dut (.*);

  always #20 clk = ~clk;   // 40 ns period

  // ============================================================
  // Reference model and instruction builders
  // ============================================================
  function automatic logic condModel(input logic [3:0] cond, input armIsaPkg::flagsT f);
    logic n;
    logic z;
    logic c;
    logic v;
    logic base;
    n = f[3];
    z = f[2];
    c = f[1];
    v = f[0];
    case (cond[3:1])                  // Pairs share a test
      3'd0:    base = z;
      3'd1:    base = c;
      3'd2:    base = n;
      3'd3:    base = v;
      3'd4:    base = c && !z;          // HI
      3'd5:    base = (n == v);         // GE
      3'd6:    base = !z && (n == v);   // GT
      default: base = 1'b1;             // AL
    endcase
    return base ^ cond[0];              // Odd code is the inverse, NV never
  endfunction

  function automatic armIsaPkg::byteMaskT maskModel(input logic isByte,
                                                    input armIsaPkg::byteOffsetT addr);
    armIsaPkg::byteMaskT m;
    m = 4'b1111;                        // Word access
    if (isByte) begin
      for (int i = 0; i < 4; i++) begin
        m[i] = (addr == 2'(i));
      end
    end
    return m;
  endfunction

  // Immediate form data processing
  function automatic armIsaPkg::instrT dpInstr(input logic [3:0] cond, input armIsaPkg::aluOpT op,
                                               input logic s, input logic [3:0] rd);
    return {cond, 2'b00, 1'b1, op, s, 4'd0, rd, 12'h001};
  endfunction

  // Immediate offset, pre-indexed, Rn = R0, Rd = R1
  function automatic armIsaPkg::instrT memInstr(input logic [3:0] cond, input logic u,
                                                input logic b, input logic l);
    return {cond, 2'b01, 1'b0, 1'b1, u, b, 1'b0, l, 4'd0, 4'd1, 12'h004};
  endfunction

  function automatic armIsaPkg::instrT brInstr(input logic [3:0] cond);
    return {cond, 3'b101, 1'b0, 24'h000010};
  endfunction

  // ============================================================
  // Drive, wait and check
  // ============================================================
  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR: %s = 0x%0h, expected 0x%0h", name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic advance(input int n);
    repeat (n) begin
      @(posedge clk);
      @(negedge clk);                   // Outputs settled
    end
  endtask

  // Returns at the negedge with the instruction in E
  task automatic issue(input armIsaPkg::instrT instr, input armIsaPkg::flagsT flags,
                       input armIsaPkg::byteOffsetT addr);
    @(posedge clk);
    instrD <= instr;
    @(negedge clk);                     // Decode selects for this instruction
    regSrcSeen = regSrcD;
    immSrcSeen = immSrcD;
    @(posedge clk);                     // Enters E
    instrD    <= nopInstr;
    aluFlagsE <= flags;                 // Datapath results for that E cycle
    aluAddrE  <= addr;
    @(negedge clk);
  endtask

  task automatic waitWriteback(input int limit, output int cycles);
    cycles = 0;
    do begin
      advance(1);
      cycles++;
    end while (!(regWriteW || pcSrcW) && cycles < limit);
    if (!(regWriteW || pcSrcW)) begin
      $display("Timed out after %0d cycles waiting for a writeback enable", cycles);
      $display("FAIL: see errors above");
      $fatal(1, "Writeback timeout");
    end
  endtask

  task automatic checkIdle();
    checkValue("{memWriteM,regWriteM,regWriteW,pcSrcW,branchTakenE,pcWrPendingF,flagsW}",
               {memWriteM, regWriteM, regWriteW, pcSrcW, branchTakenE, pcWrPendingF, flagsW},
               '0);
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic resetTest();
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      if (i == 4) rstN <= 1'b1;         // Low for five edges
      @(negedge clk);
      checkIdle();
    end
    advance(1);
    checkIdle();                        // Still quiet once released
  endtask

  task automatic conditionTest();
    armIsaPkg::flagsT f;
    int               c;
    repeat (3) begin
      f = armIsaPkg::flagsT'($random(seed));
      issue(dpInstr(condAl, armIsaPkg::opSub, 1'b1, 4'd1), f, 2'd0);   // SUBS
      advance(3);
      checkValue("flagsW", flagsW, f);
      curFlags = f;
      for (c = 0; c < 16; c++) begin
        issue(dpInstr(4'(c), armIsaPkg::opAdd, 1'b0, 4'd2), 4'h0, 2'd0);
        advance(2);
        checkValue("regWriteW", regWriteW, condModel(4'(c), f));
      end
    end
  endtask

  task automatic compareTest();
    armIsaPkg::flagsT f;
    f = armIsaPkg::flagsT'($random(seed));
    issue(dpInstr(condAl, armIsaPkg::opCmp, 1'b1, 4'd0), f, 2'd0);
    checkValue("regSrcD", regSrcSeen, 2'b00);   // Rn and Rm from the register file
    checkValue("immSrcD", immSrcSeen, 2'b00);   // Rotated imm8
    checkValue("aluControlE", aluControlE, armIsaPkg::opCmp);
    advance(2);
    checkValue("regWriteW", regWriteW, 1'b0);   // Flags only
    advance(1);
    checkValue("flagsW", flagsW, f);
    curFlags = f;
  endtask

  task automatic memoryTest();
    int cycles;
    issue(memInstr(condAl, 1'b1, 1'b0, 1'b0), 4'h0, 2'd0);   // STR, U set
    checkValue("regSrcD", regSrcSeen, 2'b10);               // Rd as store data
    checkValue("immSrcD", immSrcSeen, 2'b01);               // imm12 offset
    checkValue("aluControlE", aluControlE, armIsaPkg::opAdd);
    checkValue("aluSrcE", aluSrcE, 1'b1);
    advance(1);
    checkValue("memWriteM", memWriteM, 1'b1);
    checkValue("byteMaskM", byteMaskM, maskModel(1'b0, 2'd0));
    issue(memInstr(condAl, 1'b0, 1'b0, 1'b1), 4'h0, 2'd0);   // LDR, U clear
    checkValue("regSrcD", regSrcSeen, 2'b00);
    checkValue("aluControlE", aluControlE, armIsaPkg::opSub);
    advance(1);
    checkValue("memtoRegM", memtoRegM, 1'b1);
    checkValue("regWriteM", regWriteM, 1'b1);
    waitWriteback(4, cycles);
    checkValue("LDR writeback latency", cycles, 1);
    checkValue("memtoRegW", memtoRegW, 1'b1);
    for (int a = 0; a < 4; a++) begin                      // STRB on each lane
      issue(memInstr(condAl, 1'b1, 1'b1, 1'b0), 4'h0, 2'(a));
      advance(1);
      checkValue("byteMaskM", byteMaskM, maskModel(1'b1, 2'(a)));
    end
    issue(memInstr(condAl, 1'b1, 1'b1, 1'b1), 4'h0, 2'd3);   // LDRB
    waitWriteback(4, cycles);
    checkValue("loadByteW", loadByteW, 1'b1);
    checkValue("byteOffsetW", byteOffsetW, 2'd3);
  endtask

  task automatic branchTest();
    logic [3:0] metCond;
    int         cycles;
    metCond = condModel(4'h0, curFlags) ? 4'h0 : 4'h1;    // EQ or NE, whichever passes
    issue(brInstr(metCond), 4'h0, 2'd0);
    checkValue("regSrcD", regSrcSeen, 2'b01);              // PC as base
    checkValue("immSrcD", immSrcSeen, 2'b10);              // imm24 word offset
    checkValue("aluSrcE", aluSrcE, 1'b1);
    checkValue("branchTakenE", branchTakenE, 1'b1);
    checkValue("pcWrPendingF", pcWrPendingF, 1'b1);
    advance(2);
    checkValue("pcSrcW", pcSrcW, 1'b1);
    issue(brInstr(metCond ^ 4'h1), 4'h0, 2'd0);           // Inverse fails
    checkValue("branchTakenE", branchTakenE, 1'b0);
    advance(2);
    checkValue("pcSrcW", pcSrcW, 1'b0);
    issue(dpInstr(condAl, armIsaPkg::opMov, 1'b0, 4'(`RD_PC)), 4'h0, 2'd0);
    checkValue("pcWrPendingF", pcWrPendingF, 1'b1);
    waitWriteback(4, cycles);
    checkValue("MOV PC writeback latency", cycles, 2);
    checkValue("pcSrcW", pcSrcW, 1'b1);
  endtask

  task automatic stallFlushTest(input int k);
    int cycles;
    @(posedge clk);
    instrD <= memInstr(condAl, 1'b0, 1'b0, 1'b0);          // STR, SUB in E
    @(posedge clk);
    instrD <= dpInstr(condAl, armIsaPkg::opAdd, 1'b0, 4'd3);
    stallE <= 1'b1;
    for (int i = 1; i <= k; i++) begin
      @(posedge clk);
      if (i == k) stallE <= 1'b0;
      @(negedge clk);
      checkValue("aluControlE", aluControlE, armIsaPkg::opSub);   // E held
    end
    @(posedge clk);
    instrD <= nopInstr;                                    // ADD now in E
    waitWriteback(8, cycles);
    checkValue("stalled writeback latency", k + 1 + cycles, k + 3);
    @(posedge clk);
    instrD <= dpInstr(condAl, armIsaPkg::opAdd, 1'b0, 4'd4);
    flushE <= 1'b1;
    @(posedge clk);
    instrD <= nopInstr;
    flushE <= 1'b0;
    @(negedge clk);
    checkValue("aluSrcE", aluSrcE, 1'b0);                  // Bubble in E
    repeat (3) begin
      advance(1);
      checkValue("regWriteW", regWriteW, 1'b0);            // Bubble only
    end
  endtask

  initial begin
    seed       = 32'h1068_577f;
    clk        = 1'b0;
    rstN       = 1'b0;
    instrD     = nopInstr;
    aluFlagsE  = '0;
    aluAddrE   = '0;
    stallE     = 1'b0;
    flushE     = 1'b0;
    stallM     = 1'b0;
    stallW     = 1'b0;
    flushW     = 1'b0;
    curFlags   = '0;
    regSrcSeen = '0;
    immSrcSeen = '0;
    resetTest();
    conditionTest();
    compareTest();
    memoryTest();
    branchTest();
    stallFlushTest(3);
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+common
common/armIsaPkg.sv
common/ctrlPipePkg.sv
decode/instrDecoder.sv
execute/condExecute.sv
result/statusWriteback.sv
source/armController.sv
tb/armController_sva.sv
tb/armController_tb.sv
